// File: common/addu_cfg.svh
// Width, input queue depth, output credit and counter width macros
`ifndef ADDU_CFG_SVH
`define ADDU_CFG_SVH

// Operand and result width in bits
`define ADDU_WIDTH 20

// Input queue slots, equal to the sender's starting credits
`define ADDU_IN_DEPTH 4

// Output credits granted by the receiver at start
`define ADDU_OUT_CREDITS 2

// Credit counter width, wide enough for the credit total
`define ADDU_CNT_W 3

`endif

// File: common/addu_pkg.sv
// Operand, opcode, request, flag, response, credit and FSM state types
`include "addu_cfg.svh"

package addu_pkg;

	// Data word of one operand or sum
	typedef logic [`ADDU_WIDTH-1:0] operand_t;

	// Output credit count
	typedef logic [`ADDU_CNT_W-1:0] credit_cnt_t;

	typedef enum logic [1:0] {
		OP_ADD      = 2'd0,
		OP_SUB      = 2'd1,
		OP_ACC_ADD  = 2'd2,
		OP_ACC_LOAD = 2'd3
	} addu_op_e;

	// One request as it arrives and waits in the queue
	typedef struct packed {
		addu_op_e op;
		operand_t a;
		operand_t b;
	} addu_req_t;

	typedef struct packed {
		logic carry;
		logic overflow;
		logic zero;
		logic negative;
	} addu_flags_t;

	// Registered response leaving the unit
	typedef struct packed {
		operand_t    sum;
		addu_flags_t flags;
	} addu_rsp_t;

	// Idle lasts one cycle after reset while credits load
	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_RUN  = 1'b1
	} ctrl_state_e;

endpackage

// File: design/addu_ctrl.sv
// Issue control FSM, output credit counter and input credit return
`timescale 1ns/1ps
`include "addu_cfg.svh"

module addu_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic queue_empty,
	input  logic out_credit_ret,
	output logic issue,
	output logic in_credit_ret
);

	addu_pkg::ctrl_state_e state;
	addu_pkg::credit_cnt_t credit_cnt;
	logic                  credit_avail;

	assign credit_avail = (credit_cnt != '0);

	// Issuing spends an output credit up front, so an issued
	// result always has a slot two cycles later
	assign issue = (state == addu_pkg::ST_RUN) && !queue_empty && credit_avail;

	// One credit back to the sender per request popped
	assign in_credit_ret = issue;

	// Idle lasts the one cycle that loads the credit counter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= addu_pkg::ST_IDLE;
		end else begin
			state <= addu_pkg::ST_RUN;
		end
	end

	// Loaded with the receiver's grant in idle, then tracks
	// spend on issue and return from the receiver
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credit_cnt <= '0;
		end else begin
			case (state)
				addu_pkg::ST_IDLE: begin
					credit_cnt <= addu_pkg::credit_cnt_t'(`ADDU_OUT_CREDITS);
				end
				default: begin
					case ({issue, out_credit_ret})
						2'b10:   credit_cnt <= credit_cnt - 1'b1;
						2'b01:   credit_cnt <= credit_cnt + 1'b1;
						default: credit_cnt <= credit_cnt;
					endcase
				end
			endcase
		end
	end

endmodule

// File: design/addu_top.sv
// Top level of the add/subtract unit, wiring control, operand stage, adder and result stage
`timescale 1ns/1ps
`include "addu_cfg.svh"

module addu_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  addu_pkg::addu_req_t in_req,
	output logic                in_credit_ret,
	output logic                out_valid,
	output addu_pkg::addu_rsp_t out_rsp,
	input  logic                out_credit_ret
);

	logic               queue_empty;
	logic               issue;
	logic               op_valid;
	addu_pkg::addu_op_e op;
	addu_pkg::operand_t x;
	addu_pkg::operand_t y;
	logic               carry_in;
	addu_pkg::operand_t sum;
	logic               carry_out;
	logic               msb_carry;
	addu_pkg::operand_t acc;

	addu_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.queue_empty    (queue_empty),
		.out_credit_ret (out_credit_ret),
		.issue          (issue),
		.in_credit_ret  (in_credit_ret)
	);

	operand_stage u_operand (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_req      (in_req),
		.issue       (issue),
		.acc         (acc),
		.queue_empty (queue_empty),
		.op_valid    (op_valid),
		.op          (op),
		.x           (x),
		.y           (y),
		.carry_in    (carry_in)
	);

	// Combinational between the operand and result registers
	prefix_adder u_adder (
		.x         (x),
		.y         (y),
		.carry_in  (carry_in),
		.sum       (sum),
		.carry_out (carry_out),
		.msb_carry (msb_carry)
	);

	result_stage u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.op_valid  (op_valid),
		.op        (op),
		.sum       (sum),
		.carry_out (carry_out),
		.msb_carry (msb_carry),
		.acc       (acc),
		.out_valid (out_valid),
		.out_rsp   (out_rsp)
	);

endmodule

// File: design/operand_stage.sv
// Input request queue, operand register and adder input selection by opcode
`timescale 1ns/1ps
`include "addu_cfg.svh"

module operand_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  addu_pkg::addu_req_t in_req,
	input  logic                issue,
	input  addu_pkg::operand_t  acc,
	output logic                queue_empty,
	output logic                op_valid,
	output addu_pkg::addu_op_e  op,
	output addu_pkg::operand_t  x,
	output addu_pkg::operand_t  y,
	output logic                carry_in
);

	localparam int DEPTH = `ADDU_IN_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	addu_pkg::addu_req_t queue_mem [DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	addu_pkg::addu_req_t req_q;

	assign queue_empty = (count == '0);

	// Sender credits keep a push from hitting a full queue
	always_ff @(posedge clk) begin
		if (in_valid) begin
			queue_mem[wr_ptr] <= in_req;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (issue) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({in_valid, issue})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Operand register, loaded from the queue head on issue
	always_ff @(posedge clk) begin
		if (issue) begin
			req_q <= queue_mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= issue;
		end
	end

	assign op = req_q.op;

	// Subtract as a + ~b + 1
	always_comb begin
		x        = req_q.a;
		y        = req_q.b;
		carry_in = 1'b0;
		case (req_q.op)
			addu_pkg::OP_SUB: begin
				y        = ~req_q.b;
				carry_in = 1'b1;
			end
			addu_pkg::OP_ACC_ADD: begin
				x = acc;
				y = req_q.a;
			end
			addu_pkg::OP_ACC_LOAD: begin
				y = '0;
			end
			default: begin
				y = req_q.b;
			end
		endcase
	end

endmodule

// File: design/result_stage.sv
// Flag computation, response register and accumulator
`timescale 1ns/1ps
`include "addu_cfg.svh"

module result_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               op_valid,
	input  addu_pkg::addu_op_e op,
	input  addu_pkg::operand_t sum,
	input  logic               carry_out,
	input  logic               msb_carry,
	output addu_pkg::operand_t acc,
	output logic               out_valid,
	output addu_pkg::addu_rsp_t out_rsp
);

	addu_pkg::addu_flags_t flags;
	logic                  acc_write;

	// For SUB a set carry means no borrow
	always_comb begin
		flags.carry    = carry_out;
		flags.overflow = msb_carry ^ carry_out;
		flags.zero     = (sum == '0);
		flags.negative = sum[`ADDU_WIDTH-1];
	end

	assign acc_write = op_valid &&
		((op == addu_pkg::OP_ACC_ADD) || (op == addu_pkg::OP_ACC_LOAD));

	always_ff @(posedge clk) begin
		if (op_valid) begin
			out_rsp.sum   <= sum;
			out_rsp.flags <= flags;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= op_valid;
		end
	end

	// Written on the same edge as the result, so the next
	// accumulate op in the operand register already sees it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (acc_write) begin
			acc <= sum;
		end
	end

endmodule

// File: prefix_adder/ladner_fischer_tree.sv
// Ladner-Fischer carry tree built by generate loops with inline black and grey cells
`timescale 1ns/1ps
`include "addu_cfg.svh"

module ladner_fischer_tree (
	input  addu_pkg::operand_t p,
	input  addu_pkg::operand_t g,
	output addu_pkg::operand_t c
);

	localparam int W      = `ADDU_WIDTH;
	localparam int STAGES = (W > 1) ? $clog2(W) : 1;

	// Group generate and propagate per stage, row 0 is the bit level input
	wire [STAGES:0][W-1:0] gs;
	wire [STAGES:0][W-1:0] ps;
	wire [W-1:0]           carry;

	assign gs[0] = g;
	assign ps[0] = p;

	genvar s, i;
	generate
		// Odd positions only, each odd-aligned span takes the group
		// ending just below its midpoint
		for (s = 1; s <= STAGES; s++) begin : g_stage
			for (i = 0; i < W; i++) begin : g_bit
				localparam int M = i >> (s - 1);
				localparam int J = (M << (s - 1)) - 1;
				localparam bit ACTIVE = (i % 2 == 1) && (M % 2 == 1);
				localparam bit TO_ZERO = (M == 1);

				if (ACTIVE && TO_ZERO) begin : g_grey
					// Span reaches bit 0, no group propagate needed
					assign gs[s][i] = gs[s-1][i] | (ps[s-1][i] & gs[s-1][J]);
					assign ps[s][i] = 1'b0;
				end else if (ACTIVE) begin : g_black
					assign gs[s][i] = gs[s-1][i] | (ps[s-1][i] & gs[s-1][J]);
					assign ps[s][i] = ps[s-1][i] & ps[s-1][J];
				end else begin : g_pass
					assign gs[s][i] = gs[s-1][i];
					assign ps[s][i] = ps[s-1][i];
				end
			end
		end

		// Odd positions are complete prefixes now
		// Extra grey row fills the even ones
		for (i = 0; i < W; i++) begin : g_carry
			if (i == 0) begin : g_low
				assign carry[i] = g[0];
			end else if (i % 2 == 1) begin : g_odd
				assign carry[i] = gs[STAGES][i];
			end else begin : g_even
				assign carry[i] = g[i] | (p[i] & gs[STAGES][i-1]);
			end
		end
	endgenerate

	assign c = carry;

endmodule

// File: prefix_adder/prefix_adder.sv
// Parallel-prefix adder with propagate/generate setup, carry tree and sum logic
`timescale 1ns/1ps
`include "addu_cfg.svh"

module prefix_adder (
	input  addu_pkg::operand_t x,
	input  addu_pkg::operand_t y,
	input  logic               carry_in,
	output addu_pkg::operand_t sum,
	output logic               carry_out,
	output logic               msb_carry
);

	localparam int W = `ADDU_WIDTH;

	// Extended vectors, position 0 holds the carry-in
	logic [W:0] p_ext;
	logic [W:0] g_ext;
	addu_pkg::operand_t carry;

	// Pre-computation
	assign p_ext = {x ^ y, 1'b0};
	assign g_ext = {x & y, carry_in};

	// carry[k] is the carry into bit k
	ladner_fischer_tree u_tree (
		.p (p_ext[W-1:0]),
		.g (g_ext[W-1:0]),
		.c (carry)
	);

	// Post-computation
	assign sum       = p_ext[W:1] ^ carry;
	assign carry_out = g_ext[W] | (p_ext[W] & carry[W-1]);

	// Carry into the sign bit, compared with carry_out for overflow
	assign msb_carry = carry[W-1];

endmodule

// File: sim.f
+incdir+common
common/addu_pkg.sv
prefix_adder/ladner_fischer_tree.sv
prefix_adder/prefix_adder.sv
design/operand_stage.sv
design/result_stage.sv
design/addu_ctrl.sv
design/addu_top.sv
tests/addu_props.sv
tests/addu_tb.sv

// File: tests/addu_props.sv
// Bound assertions on queue occupancy, output credits, latency and credit return
`timescale 1ns/1ps
`include "addu_cfg.svh"

module addu_props (
	input logic                                  clk,
	input logic                                  rst_n,
	input logic                                  in_valid,
	input logic                                  issue,
	input logic                                  in_credit_ret,
	input logic                                  out_valid,
	input logic [$clog2(`ADDU_IN_DEPTH + 1)-1:0] q_count,
	input addu_pkg::credit_cnt_t                 credit_cnt
);

	// A push into a full queue would overwrite a waiting request
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (q_count < `ADDU_IN_DEPTH))
		else $error("input queue overflow");

	// Counter is unsigned, so a spend at zero wraps above the grant
	a_credit_ceiling: assert property (@(posedge clk) disable iff (!rst_n)
		credit_cnt <= `ADDU_OUT_CREDITS)
		else $error("output credit count outside zero to the grant");

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> ##2 out_valid)
		else $error("issued request missing at out_valid two cycles later");

	// Queue occupancy moves by pushes minus credits sent back
	a_credit_ret: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> (int'(q_count) ==
			int'($past(q_count)) + int'($past(in_valid)) - int'($past(in_credit_ret))))
		else $error("input credit return does not match a queue pop");

endmodule

bind addu_top addu_props u_props (
	.clk           (clk),
	.rst_n         (rst_n),
	.in_valid      (in_valid),
	.issue         (issue),
	.in_credit_ret (in_credit_ret),
	.out_valid     (out_valid),
	.q_count       (u_operand.count),
	.credit_cnt    (u_ctrl.credit_cnt)
);

// File: tests/addu_tb.sv
// Testbench with clock, reset, random requests, credit models, reference model and checks
`timescale 1ns/1ps
`include "addu_cfg.svh"

module addu_tb;

	localparam int W           = `ADDU_WIDTH;
	localparam int DEPTH       = `ADDU_IN_DEPTH;
	localparam int OUT_CR      = `ADDU_OUT_CREDITS;
	localparam int NUM_REQ     = 300;
	localparam int HOLD_AT     = 150;
	localparam int HOLD_CYCLES = 50;
	localparam int IDLE_CYCLES = 5;
	localparam int TIMEOUT     = NUM_REQ * 20 + 200;

	logic                clk;
	logic                rst_n;
	logic                in_valid;
	addu_pkg::addu_req_t in_req;
	logic                in_credit_ret;
	logic                out_valid;
	addu_pkg::addu_rsp_t out_rsp;
	logic                out_credit_ret;

	logic [31:0]         rng_state = 32'd82998;
	addu_pkg::addu_rsp_t exp_q[$];
	int                  ret_q[$];
	addu_pkg::operand_t  model_acc = '0;
	int errors = 0;
	int sent = 0;
	int recv_count = 0;
	int ret_count = 0;
	int sender_credits = DEPTH;
	int recv_credits = OUT_CR;
	int run_cyc = 0;
	int hold_end = 0;
	int hold_out = 0;
	int cycle_count = 0;

	addu_top dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_req         (in_req),
		.in_credit_ret  (in_credit_ret),
		.out_valid      (out_valid),
		.out_rsp        (out_rsp),
		.out_credit_ret (out_credit_ret)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Corner values show up often enough to hit overflow both ways
	function automatic addu_pkg::operand_t rand_operand();
		logic [31:0] r;
		r = next_rand();
		case (r[2:0])
			3'd0:    return '0;
			3'd1:    return '1;
			3'd2:    return addu_pkg::operand_t'(1 << (W - 1));
			3'd3:    return addu_pkg::operand_t'((1 << (W - 1)) - 1);
			default: return r[31:32-W];
		endcase
	endfunction

	// Reference result from plain wide arithmetic
	function automatic addu_pkg::addu_rsp_t model_rsp(addu_pkg::addu_req_t req,
		addu_pkg::operand_t acc_in);
		logic [W:0]          wide;
		addu_pkg::operand_t  lhs;
		addu_pkg::operand_t  rhs;
		addu_pkg::addu_rsp_t rsp;
		rsp = '0;
		lhs = (req.op == addu_pkg::OP_ACC_ADD) ? acc_in : req.a;
		rhs = (req.op == addu_pkg::OP_ACC_ADD) ? req.a : req.b;
		case (req.op)
			addu_pkg::OP_SUB: begin
				wide = {1'b0, req.a} - {1'b0, req.b};
				rsp.sum = wide[W-1:0];
				rsp.flags.carry = (req.a >= req.b);
				rsp.flags.overflow = (req.a[W-1] != req.b[W-1]) && (rsp.sum[W-1] != req.a[W-1]);
			end
			addu_pkg::OP_ACC_LOAD: begin
				rsp.sum = req.a;
			end
			default: begin
				wide = {1'b0, lhs} + {1'b0, rhs};
				rsp.sum = wide[W-1:0];
				rsp.flags.carry = wide[W];
				rsp.flags.overflow = (lhs[W-1] == rhs[W-1]) && (rsp.sum[W-1] != lhs[W-1]);
			end
		endcase
		rsp.flags.zero = (rsp.sum == '0);
		rsp.flags.negative = rsp.sum[W-1];
		return rsp;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic receive_rsp();
		addu_pkg::addu_rsp_t exp;
		if (run_cyc < hold_end) begin
			hold_out++;
		end
		if (recv_credits == 0) begin
			errors++;
			$display("Receiver saw a result while holding no output credit");
		end else begin
			recv_credits--;
		end
		if (exp_q.size() == 0) begin
			errors++;
			$display("Result arrived with no request outstanding");
		end else begin
			exp = exp_q.pop_front();
			check_value("out_rsp.sum", out_rsp.sum, exp.sum);
			check_value("out_rsp.flags.carry", out_rsp.flags.carry, exp.flags.carry);
			check_value("out_rsp.flags.overflow", out_rsp.flags.overflow, exp.flags.overflow);
			check_value("out_rsp.flags.zero", out_rsp.flags.zero, exp.flags.zero);
			check_value("out_rsp.flags.negative", out_rsp.flags.negative, exp.flags.negative);
			recv_count++;
		end
		ret_q.push_back(run_cyc + int'(next_rand() % 7));
	endtask

	// One credit pulse per cycle at most, none during the hold window
	task automatic return_credit();
		out_credit_ret <= 1'b0;
		if (run_cyc >= hold_end && ret_q.size() != 0 && ret_q[0] <= run_cyc) begin
			out_credit_ret <= 1'b1;
			void'(ret_q.pop_front());
			recv_credits++;
		end
	endtask

	task automatic send_req();
		addu_pkg::addu_req_t req;
		addu_pkg::addu_rsp_t exp;
		logic [31:0]         r;
		in_valid <= 1'b0;
		if (sent == HOLD_AT && hold_end == 0) begin
			hold_end = run_cyc + HOLD_CYCLES;
		end
		if (run_cyc > IDLE_CYCLES && sent < NUM_REQ && sender_credits > 0) begin
			r = next_rand();
			if (r[1:0] != 2'b00) begin
				// First request checks the accumulator reset value
				if (sent == 0) begin
					req.op = addu_pkg::OP_ACC_ADD;
				end else begin
					req.op = r[5] ? addu_pkg::OP_ACC_ADD : addu_pkg::addu_op_e'(r[4:3]);
				end
				req.a = rand_operand();
				req.b = rand_operand();
				exp = model_rsp(req, model_acc);
				if (req.op == addu_pkg::OP_ACC_ADD || req.op == addu_pkg::OP_ACC_LOAD) begin
					model_acc = exp.sum;
				end
				exp_q.push_back(exp);
				in_req <= req;
				in_valid <= 1'b1;
				sender_credits--;
				sent++;
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			run_cyc++;
			if (run_cyc <= IDLE_CYCLES) begin
				check_value("out_valid", out_valid, 1'b0);
				check_value("in_credit_ret", in_credit_ret, 1'b0);
			end
			if (in_credit_ret) begin
				sender_credits++;
				ret_count++;
			end
			if (out_valid) begin
				receive_rsp();
			end
			return_credit();
			send_req();
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT) begin
			$display("Timeout after %0d cycles with %0d of %0d results received",
				cycle_count, recv_count, NUM_REQ);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_req = '0;
		out_credit_ret = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		while (recv_count < NUM_REQ || ret_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		check_value("received count", recv_count, NUM_REQ);
		check_value("in_credit_ret count", ret_count, sent);
		check_value("sender credits", sender_credits, DEPTH);
		check_value("receiver credits", recv_credits, OUT_CR);
		if (exp_q.size() != 0) begin
			errors++;
			$display("Requests left without a result: %0d", exp_q.size());
		end
		if (hold_out > OUT_CR) begin
			errors++;
			$display("Output kept flowing while credits were withheld");
		end
		$display("Finished %0d requests with %0d errors", recv_count, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
